// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = invaders_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
hdl/invaders_pkg.sv
hdl/march_timer.sv
hdl/alien_field.sv
hdl/hit_detect.sv
hdl/game_ctrl.sv
hdl/frame_streamer.sv
hdl/invaders_top.sv
tests/invaders_checker.sv
tests/invaders_tb.sv

// ==== hdl/alien_field.sv ====
//==============================
// Hit clearing is applied to the field after any march move of the same cycle
//==============================
module alien_field (
	input  logic                 clock_50,
	input  logic                 rst_n,
	input  logic                 load,
	input  invaders_pkg::level_t level,
	input  logic                 march_tick,
	input  invaders_pkg::field_t hit_mask,
	output invaders_pkg::field_t field
);

	localparam int MSB = invaders_pkg::MATRIX_SIZE - 1;

	invaders_pkg::field_t moved;
	logic dir_right;                                 // Current march direction
	logic at_edge;                                   // Some alien sits on the column ahead of the march

	//==============================
	// Next position
	//==============================
	always_comb begin
		at_edge = 1'b0;
		for (int r = 1; r <= MSB; r++) begin
			if (dir_right) begin
				at_edge = at_edge | field[r][0];
			end else begin
				at_edge = at_edge | field[r][MSB];
			end
		end

		moved = field;
		if (march_tick) begin
			if (at_edge) begin
				// Step down one row, the top row becomes empty
				moved = {invaders_pkg::row_t'(0), field[MSB:2]};
			end else begin
				for (int r = 1; r <= MSB; r++) begin
					if (dir_right) begin
						moved[r] = field[r] >> 1;       // Toward column 0
					end else begin
						moved[r] = field[r] << 1;
					end
				end
			end
		end
	end

	//==============================
	// Formation register
	//==============================
	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			field     <= '0;
			dir_right <= 1'b1;
		end else if (load) begin
			field     <= invaders_pkg::LEVEL_FORMATION[level]; // Fresh formation for this level
			dir_right <= 1'b1;                       // Every level starts marching right
		end else begin
			field <= moved & ~hit_mask;
			if (march_tick && at_edge) begin
				dir_right <= !dir_right;             // Turn around after the step down
			end
		end
	end

endmodule

// ==== hdl/frame_streamer.sv ====
//==============================
// All sources are sampled together when the row 0 beat is loaded
// so a frame stays whole under back-pressure
//==============================
module frame_streamer (
	input  logic                    clock_50,
	input  logic                    rst_n,
	input  invaders_pkg::field_t    field,
	input  invaders_pkg::shots_t    shots,
	input  invaders_pkg::row_t      ship_row,
	input  logic                    row_ready,
	output logic                    row_valid,
	output invaders_pkg::row_beat_t row_beat
);

	invaders_pkg::field_t    frame_q;                // Rows 7 to 1 of the frame on its way out
	invaders_pkg::field_t    composed;
	invaders_pkg::row_addr_t next_addr;              // Row of the next beat to load
	invaders_pkg::row_t      beat_data;
	logic                    load_beat;

	assign composed  = field | shots;                // Aliens and shots share rows 7 to 1
	assign load_beat = !row_valid || row_ready;      // Output slot is empty or being taken

	always_comb begin
		if (next_addr == '0) begin
			beat_data = ship_row;                    // Row 0 goes straight out at capture
		end else begin
			beat_data = frame_q[next_addr];
		end
	end

	//==============================
	// Stream control
	//==============================
	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			row_valid <= 1'b0;
			next_addr <= '0;
		end else if (load_beat) begin
			row_valid <= 1'b1;                       // Frames repeat without end
			next_addr <= next_addr + 1'b1;           // Wraps from 7 back to 0
		end
	end

	always_ff @(posedge clock_50) begin
		if (load_beat) begin
			row_beat.addr <= next_addr;
			row_beat.data <= beat_data;
			if (next_addr == '0) begin
				frame_q <= composed;
			end
		end
	end

endmodule

// ==== hdl/game_ctrl.sv ====
//==============================
// start is a one cycle pulse and is only seen in IDLE, WON and LOST
// invaded wins over cleared when both rise in the same cycle
//==============================
module game_ctrl (
	input  logic                  clock_50,
	input  logic                  rst_n,
	input  logic                  start,
	input  logic                  cleared,
	input  logic                  invaded,
	output logic                  load,
	output logic                  playing,
	output invaders_pkg::level_t  level,
	output invaders_pkg::status_t status
);

	localparam invaders_pkg::level_t FIRST_LEVEL = 2'd1;
	localparam invaders_pkg::level_t LAST_LEVEL  = invaders_pkg::level_t'(invaders_pkg::LEVEL_COUNT);

	invaders_pkg::game_state_e state;
	invaders_pkg::game_state_e state_nxt;
	invaders_pkg::level_t      level_nxt;

	//==============================
	// Next state
	//==============================
	always_comb begin
		state_nxt = state;
		level_nxt = level;
		case (state)
			invaders_pkg::IDLE: begin
				if (start) begin
					state_nxt = invaders_pkg::LOAD;
				end
			end
			invaders_pkg::LOAD: begin
				state_nxt = invaders_pkg::PLAY;      // Formation is in place after one cycle
			end
			invaders_pkg::PLAY: begin
				if (invaded) begin
					state_nxt = invaders_pkg::LOST;
				end else if (cleared) begin
					if (level == LAST_LEVEL) begin
						state_nxt = invaders_pkg::WON;
					end else begin
						state_nxt = invaders_pkg::LOAD;
						level_nxt = level + 1'b1;    // Next level loads with a faster march
					end
				end
			end
			invaders_pkg::WON,
			invaders_pkg::LOST: begin
				if (start) begin
					state_nxt = invaders_pkg::LOAD;
					level_nxt = FIRST_LEVEL;         // A new game always starts over
				end
			end
			default: begin
				state_nxt = invaders_pkg::IDLE;
			end
		endcase
	end

	//==============================
	// State and level registers
	//==============================
	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			state <= invaders_pkg::IDLE;
			level <= FIRST_LEVEL;
		end else begin
			state <= state_nxt;
			level <= level_nxt;
		end
	end

	assign load    = (state == invaders_pkg::LOAD);
	assign playing = (state == invaders_pkg::PLAY);

	always_comb begin
		status.level   = level;
		status.playing = playing;
		status.won     = (state == invaders_pkg::WON);
		status.lost    = (state == invaders_pkg::LOST);
	end

endmodule

// ==== hdl/hit_detect.sv ====
//==============================
// cleared and invaded follow the field without delay
// bullet_hit lags the overlap by one cycle
//==============================
module hit_detect (
	input  logic                 clock_50,
	input  logic                 rst_n,
	input  logic                 playing,
	input  invaders_pkg::field_t field,
	input  invaders_pkg::shots_t shots,
	output invaders_pkg::field_t hit_mask,
	output logic                 bullet_hit,
	output logic                 cleared,
	output logic                 invaded
);

	always_comb begin
		if (playing) begin
			hit_mask = field & shots;                // Aliens touched by a shot this cycle
		end else begin
			hit_mask = '0;                           // Shots do nothing outside play
		end
	end

	assign cleared = ~|field;                        // No alien left on the field
	assign invaded = |field[invaders_pkg::INVADE_ROW];

	always_ff @(posedge clock_50) begin
		if (!rst_n) begin
			bullet_hit <= 1'b0;
		end else begin
			bullet_hit <= |hit_mask;                 // Pulses once per hit, the hit aliens are gone next cycle
		end
	end

endmodule

// ==== hdl/invaders_pkg.sv ====
//==============================
// Row 0 is the ship row and row 7 the top; bit 0 is the rightmost column
// Levels run from 1 to LEVEL_COUNT and index the formation table directly
//==============================
package invaders_pkg;

	localparam int MATRIX_SIZE = 8;                  // Rows and columns of the LED matrix
	localparam int LEVEL_COUNT = 3;                  // Last level, clearing it wins the game

	typedef logic [MATRIX_SIZE-1:0] row_t;           // One matrix row, bit 0 at the right
	typedef logic [2:0] row_addr_t;                  // Row number 0 to 7
	typedef row_t [MATRIX_SIZE-1:1] field_t;         // Alien rows 7 down to 1
	typedef row_t [MATRIX_SIZE-1:1] shots_t;         // Shot rows, same shape as the field
	typedef logic [1:0] level_t;                     // Current level 1 to 3

	localparam row_addr_t INVADE_ROW = 3'd1;         // An alien here means the ship is overrun

	//==============================
	// Start formations
	//==============================
	localparam row_t ROW_EMPTY  = 8'b0000_0000;
	localparam row_t ROW_NARROW = 8'b0011_1100;      // Columns 2 to 5
	localparam row_t ROW_WIDE   = 8'b0111_1110;      // Columns 1 to 6

	localparam field_t LEVEL_FORMATION [1:LEVEL_COUNT] = '{
		{ROW_NARROW, ROW_NARROW, {5{ROW_EMPTY}}},        // Two rows of four
		{ROW_NARROW, ROW_NARROW, ROW_NARROW, {4{ROW_EMPTY}}},
		{ROW_WIDE, ROW_WIDE, ROW_WIDE, {4{ROW_EMPTY}}}   // Three rows of six
	};

	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		PLAY,
		WON,
		LOST
	} game_state_e;

	typedef struct packed {
		level_t level;
		logic   playing;
		logic   won;
		logic   lost;
	} status_t;

	typedef struct packed {
		row_addr_t addr;                             // Row this beat belongs to
		row_t      data;                             // Lit columns of that row
	} row_beat_t;

endpackage

// ==== hdl/invaders_top.sv ====
//==============================
// shots and ship_row are sampled every cycle, only the row stream handshakes
//==============================
module invaders_top #(
	parameter int MOVE_PERIOD = 64
) (
	input  logic                    clock_50,
	input  logic                    rst_n,
	input  logic                    start,
	input  invaders_pkg::shots_t    shots,
	input  invaders_pkg::row_t      ship_row,
	input  logic                    row_ready,
	output invaders_pkg::status_t   status,
	output logic                    bullet_hit,
	output logic                    row_valid,
	output invaders_pkg::row_beat_t row_beat
);

	invaders_pkg::level_t level;
	invaders_pkg::field_t field;
	invaders_pkg::field_t hit_mask;
	logic load;
	logic playing;
	logic march_tick;
	logic cleared;
	logic invaded;

	game_ctrl u_game_ctrl (                          // Game FSM and level register
		.clock_50 (clock_50),
		.rst_n    (rst_n),
		.start    (start),
		.cleared  (cleared),
		.invaded  (invaded),
		.load     (load),
		.playing  (playing),
		.level    (level),
		.status   (status)
	);

	march_timer #(
		.MOVE_PERIOD (MOVE_PERIOD)
	) u_march_timer (                                // March speed of the current level
		.clock_50   (clock_50),
		.rst_n      (rst_n),
		.playing    (playing),
		.level      (level),
		.march_tick (march_tick)
	);

	alien_field u_alien_field (
		.clock_50   (clock_50),
		.rst_n      (rst_n),
		.load       (load),
		.level      (level),
		.march_tick (march_tick),
		.hit_mask   (hit_mask),
		.field      (field)
	);

	hit_detect u_hit_detect (
		.clock_50   (clock_50),
		.rst_n      (rst_n),
		.playing    (playing),
		.field      (field),
		.shots      (shots),
		.hit_mask   (hit_mask),
		.bullet_hit (bullet_hit),
		.cleared    (cleared),
		.invaded    (invaded)
	);

	frame_streamer u_frame_streamer (                // Display port toward the matrix driver
		.clock_50  (clock_50),
		.rst_n     (rst_n),
		.field     (field),
		.shots     (shots),
		.ship_row  (ship_row),
		.row_ready (row_ready),
		.row_valid (row_valid),
		.row_beat  (row_beat)
	);

endmodule

// ==== hdl/march_timer.sv ====
//==============================
// MOVE_PERIOD must be at least 4 so that level 3 still has a nonzero period
//==============================
module march_timer #(
	parameter int MOVE_PERIOD = 64
) (
	input  logic                 clock_50,
	input  logic                 rst_n,
	input  logic                 playing,
	input  invaders_pkg::level_t level,
	output logic                 march_tick
);

	localparam int CNT_W = $clog2(MOVE_PERIOD + 1);

	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] period;

	assign period = CNT_W'(MOVE_PERIOD >> (level - 2'd1)); // Each level halves the period

	always_ff @(posedge clock_50) begin
		if (!rst_n || !playing) begin
			count      <= '0;                        // Restart so every level begins with a full wait
			march_tick <= 1'b0;
		end else if (count >= period - 1'b1) begin
			count      <= '0;                        // Also catches a period that shrank mid count
			march_tick <= 1'b1;
		end else begin
			count      <= count + 1'b1;
			march_tick <= 1'b0;
		end
	end

endmodule

// ==== tests/invaders_checker.sv ====
//==============================
// Bound to invaders_top, all properties are off while rst_n is low
//==============================
module invaders_checker (
	input logic                    clock_50,
	input logic                    rst_n,
	input invaders_pkg::status_t   status,
	input logic                    bullet_hit,
	input logic                    row_valid,
	input logic                    row_ready,
	input invaders_pkg::row_beat_t row_beat
);

	beat_held: assert property (@(posedge clock_50) disable iff (!rst_n)
		row_valid && !row_ready |=> row_valid && $stable(row_beat))
		else $error("Row beat changed while held under back-pressure");

	single_outcome: assert property (@(posedge clock_50) disable iff (!rst_n)
		!(status.won && status.lost))
		else $error("Game shows won and lost together");

	hit_in_play: assert property (@(posedge clock_50) disable iff (!rst_n)
		bullet_hit |-> $past(status.playing))
		else $error("Hit flag raised without play in the cycle before");

	level_range: assert property (@(posedge clock_50) disable iff (!rst_n)
		status.level != 2'd0)                    // Two bits leave zero as the only illegal level
		else $error("Level left the range 1 to 3");

endmodule

bind invaders_top invaders_checker u_checker (
	.clock_50   (clock_50),
	.rst_n      (rst_n),
	.status     (status),
	.bullet_hit (bullet_hit),
	.row_valid  (row_valid),
	.row_ready  (row_ready),
	.row_beat   (row_beat)
);

// ==== tests/invaders_tb.sv ====
//==============================
// Directed tests of invaders_top built with MOVE_PERIOD 16
// Inputs change 1 time unit after a rising edge and outputs are read at that point
//==============================
module invaders_tb;

	localparam int MOVE_PERIOD    = 16;
	localparam int TIMEOUT_CYCLES = 20000;       // The invasion test alone needs about 400 cycles
	localparam invaders_pkg::row_t FULL_ROW = 8'hFF;
	localparam invaders_pkg::row_t L1_ROW   = 8'b0011_1100; // Level 1 aliens sit in columns 2 to 5

	logic                    clock_50;
	logic                    rst_n;
	logic                    start;
	invaders_pkg::shots_t    shots;
	invaders_pkg::row_t      ship_row;
	logic                    row_ready;
	invaders_pkg::status_t   status;
	logic                    bullet_hit;
	logic                    row_valid;
	invaders_pkg::row_beat_t row_beat;

	int     cycles = 0;
	integer seed   = 96550;
	logic   random_ready;                        // Random back-pressure on the row stream when set

	invaders_top #(
		.MOVE_PERIOD (MOVE_PERIOD)
	) DUT (
		.clock_50   (clock_50),
		.rst_n      (rst_n),
		.start      (start),
		.shots      (shots),
		.ship_row   (ship_row),
		.row_ready  (row_ready),
		.status     (status),
		.bullet_hit (bullet_hit),
		.row_valid  (row_valid),
		.row_beat   (row_beat)
	);

	always #5 clock_50 = ~clock_50;

	always @(posedge clock_50) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
			stop_run();
		end
	end

	//==============================
	// Helpers
	//==============================
	task automatic stop_run();
		$display("Simulation failed");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic compare_values(input string what, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("error at time %0t: %s is %0h, expected %0h", $time, what, actual, expected);
			stop_run();
		end
	endtask

	task automatic tick();
		@(posedge clock_50);
		#1;
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		start = 1'b0;
		repeat (8) tick();
		rst_n = 1'b1;
	endtask

	task automatic start_game();
		start = 1'b1;
		tick();
		start = 1'b0;
		while (!status.playing) tick();          // LOAD takes one cycle before PLAY
	endtask

	// Waits for the next accepted beat whose transfer happens at the edge inside tick
	task automatic take_beat(output invaders_pkg::row_beat_t beat);
		logic [31:0] rnd;
		logic        got;
		got = 1'b0;
		while (!got) begin
			rnd       = $random(seed);
			row_ready = random_ready ? rnd[0] : 1'b1;
			got       = row_valid && row_ready;
			if (got) begin
				beat = row_beat;
			end
			tick();
		end
	endtask

	task automatic skip_to_frame_start();
		invaders_pkg::row_beat_t beat;
		do begin
			take_beat(beat);
		end while (beat.addr != 3'd7);           // The frame after it is captured from current inputs
	endtask

	// Row 0 is the ship and rows 1 to 7 hold aliens or shots
	// Rows missing from the mask are not compared
	task automatic check_frame(input invaders_pkg::field_t aliens, input logic [7:0] rows,
		input string label);
		invaders_pkg::row_beat_t beat;
		invaders_pkg::row_t      expected;
		for (int r = 0; r < invaders_pkg::MATRIX_SIZE; r++) begin
			take_beat(beat);
			expected = (r == 0) ? ship_row : (aliens[r] | shots[r]);
			compare_values({label, " row address"}, 32'(beat.addr), 32'(r));
			if (rows[r]) begin
				compare_values({label, " row data"}, 32'(beat.data), 32'(expected));
			end
		end
	endtask

	//==============================
	// Directed tests
	//==============================
	task automatic check_reset_state();
		shots    = {8'h81, 8'h42, 8'h24, 8'h18, 8'h24, 8'h42, 8'h81};
		ship_row = 8'h18;
		apply_reset();
		compare_values("level after reset", 32'(status.level), 32'd1);
		compare_values("playing after reset", 32'(status.playing), 32'd0);
		compare_values("won after reset", 32'(status.won), 32'd0);
		compare_values("lost after reset", 32'(status.lost), 32'd0);
		compare_values("bullet_hit after reset", 32'(bullet_hit), 32'd0);
		compare_values("row_valid after reset", 32'(row_valid), 32'd0);
		tick();
		compare_values("row_valid one cycle after reset", 32'(row_valid), 32'd1);
		check_frame('0, 8'hFF, "first frame");
	endtask

	task automatic stream_under_backpressure();
		shots        = {8'h40, 8'h20, 8'h10, 8'h08, 8'h04, 8'h02, 8'h01};
		ship_row     = 8'h3C;
		random_ready = 1'b1;
		skip_to_frame_start();
		repeat (3) check_frame('0, 8'hFF, "frame under back-pressure");
		random_ready = 1'b0;
	endtask

	task automatic hit_and_clear();
		shots    = '0;
		ship_row = 8'h10;
		apply_reset();
		start_game();
		shots[7] = FULL_ROW;                     // The formation still fills row 7 here
		tick();
		compare_values("bullet_hit after the shot", 32'(bullet_hit), 32'd1);
		tick();
		compare_values("bullet_hit one cycle later", 32'(bullet_hit), 32'd0);
		repeat (4) tick();
		shots = '0;
		skip_to_frame_start();
		check_frame('0, 8'b1000_0001, "frame after the hit");
		compare_values("playing after the hit", 32'(status.playing), 32'd1);
	endtask

	task automatic level_progression();
		invaders_pkg::level_t expected_level;
		shots = '0;
		apply_reset();
		start_game();
		compare_values("first level", 32'(status.level), 32'd1);
		expected_level = 2'd1;
		shots[7] = FULL_ROW;                     // Every start formation lies in rows 7 to 5
		shots[6] = FULL_ROW;
		shots[5] = FULL_ROW;
		while (!status.won) begin
			if (status.playing && status.level != expected_level) begin
				compare_values("next level", 32'(status.level), 32'(expected_level + 2'd1));
				expected_level = status.level;
			end
			tick();
		end
		compare_values("last level played", 32'(expected_level), 32'd3);
		compare_values("playing after the win", 32'(status.playing), 32'd0);
		compare_values("lost after the win", 32'(status.lost), 32'd0);
		shots = '0;
	endtask

	task automatic invasion();
		shots = '0;
		apply_reset();
		start_game();
		while (!status.lost) tick();
		compare_values("won after the invasion", 32'(status.won), 32'd0);
		compare_values("playing after the invasion", 32'(status.playing), 32'd0);
	endtask

	task automatic restart_after_loss();
		invaders_pkg::field_t formation;
		formation    = '0;
		formation[7] = L1_ROW;
		formation[6] = L1_ROW;
		shots        = '0;
		ship_row     = 8'h08;
		compare_values("lost before the restart", 32'(status.lost), 32'd1);
		start_game();
		compare_values("level after the restart", 32'(status.level), 32'd1);
		compare_values("lost after the restart", 32'(status.lost), 32'd0);
		skip_to_frame_start();                   // Done well before the first march step
		check_frame(formation, 8'hFF, "frame after the restart");
	endtask

	initial begin
		clock_50     = 1'b0;
		rst_n        = 1'b0;
		start        = 1'b0;
		shots        = '0;
		ship_row     = '0;
		row_ready    = 1'b0;
		random_ready = 1'b0;
		check_reset_state();
		stream_under_backpressure();
		hit_and_clear();
		level_progression();
		invasion();
		restart_after_loss();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule
